//--- video_window_defines.svh
////////////////////
// Widths, reset values and command lengths for the window path
// Bit 12 of an aspect value marks a direct size, not a ratio
////////////////////

`ifndef VIDEO_WINDOW_DEFINES_SVH
`define VIDEO_WINDOW_DEFINES_SVH

// Pixel or line dimension
`define VW_DIM_W 12

// Aspect value, top bit is the direct-size flag
`define VW_AR_W 13

// Host data word
`define VW_IO_W 16

// 1920x1080 until the host sends a timing command
`define VW_DEF_WIDTH 1920
`define VW_DEF_HEIGHT 1080

// Data words in the video timing command
`define VW_TIMING_WORDS 8

`endif

//--- video_window_pkg.sv
////////////////////
// Opcodes outside this list are parsed but change nothing
////////////////////

`default_nettype none

`include "video_window_defines.svh"

package video_window_pkg;

	typedef logic [`VW_DIM_W-1:0] dim_t;
	typedef logic [`VW_AR_W-1:0]  aspect_t;
	typedef logic [`VW_IO_W-1:0]  io_word_t;

	// Host opcodes, taken from the low byte of the first word
	typedef enum logic [7:0] {
		CMD_TIMING = 8'h20,
		CMD_VSET   = 8'h27,
		CMD_LFB    = 8'h2F,
		CMD_HSET   = 8'h37,
		CMD_ARC    = 8'h3A
	} cmd_t;

endpackage

`default_nettype wire

//--- hps_cmd_decode.sv
////////////////////
// No back-pressure: every request is acknowledged after the sync delay
// Host must hold data stable from before the request until the acknowledge
////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "video_window_defines.svh"

module hps_cmd_decode (
	input  wire                        clk_sys,
	input  wire                        resetd,
	input  wire                        i_io_sel,
	input  wire                        i_io_clk,
	input  wire video_window_pkg::io_word_t i_io_din,
	output logic                       o_io_ack,
	output video_window_pkg::dim_t     o_width,
	output video_window_pkg::dim_t     o_height,
	output video_window_pkg::dim_t     o_hset,
	output video_window_pkg::dim_t     o_vset,
	output logic                       o_freescale,
	output video_window_pkg::aspect_t  o_arc1x,
	output video_window_pkg::aspect_t  o_arc1y,
	output video_window_pkg::aspect_t  o_arc2x,
	output video_window_pkg::aspect_t  o_arc2y,
	output logic                       o_lfb_en,
	output video_window_pkg::dim_t     o_lfb_hmin,
	output video_window_pkg::dim_t     o_lfb_hmax,
	output video_window_pkg::dim_t     o_lfb_vmin,
	output video_window_pkg::dim_t     o_lfb_vmax
);

	logic req_s1;
	logic req_s2;
	logic sel_s1;
	logic sel_s2;
	video_window_pkg::io_word_t din_s1;
	video_window_pkg::io_word_t din_s2;
	logic word_stb;

	logic has_cmd;
	video_window_pkg::cmd_t cmd;
	logic [3:0] word_cnt;

	////////////////////
	// Host synchronisers
	////////////////////

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			req_s1   <= 1'b0;
			req_s2   <= 1'b0;
			sel_s1   <= 1'b0;
			sel_s2   <= 1'b0;
			o_io_ack <= 1'b0;
		end else begin
			req_s1   <= i_io_clk;
			req_s2   <= req_s1;
			sel_s1   <= i_io_sel;
			sel_s2   <= sel_s1;
			// Ack mirrors the synced request one cycle on
			o_io_ack <= req_s2;
		end
	end

	always_ff @(posedge clk_sys) begin
		din_s1 <= i_io_din;
		din_s2 <= din_s1;
	end

	// High for the one cycle between synced request and ack
	assign word_stb = req_s2 & ~o_io_ack;

	////////////////////
	// Command parser
	////////////////////

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			has_cmd     <= 1'b0;
			cmd         <= video_window_pkg::CMD_TIMING;
			word_cnt    <= '0;
			o_width     <= video_window_pkg::dim_t'(`VW_DEF_WIDTH);
			o_height    <= video_window_pkg::dim_t'(`VW_DEF_HEIGHT);
			o_hset      <= '0;
			o_vset      <= '0;
			o_freescale <= 1'b0;
			o_arc1x     <= '0;
			o_arc1y     <= '0;
			o_arc2x     <= '0;
			o_arc2y     <= '0;
			o_lfb_en    <= 1'b0;
			o_lfb_hmin  <= '0;
			o_lfb_hmax  <= '0;
			o_lfb_vmin  <= '0;
			o_lfb_vmax  <= '0;
		end else if (!sel_s2) begin
			// Deselect aborts whatever command was in progress
			has_cmd  <= 1'b0;
			word_cnt <= '0;
		end else if (word_stb) begin
			if (!has_cmd) begin
				has_cmd  <= 1'b1;
				cmd      <= video_window_pkg::cmd_t'(din_s2[7:0]);
				word_cnt <= '0;
			end else begin
				// Saturate so a long command never wraps back to word 0
				if (word_cnt != '1)
					word_cnt <= word_cnt + 4'd1;

				case (cmd)
					video_window_pkg::CMD_TIMING: begin
						// Porch and sync words are accepted and dropped
						if (word_cnt < 4'(`VW_TIMING_WORDS)) begin
							if (word_cnt == 4'd0)
								o_width <= din_s2[`VW_DIM_W-1:0];
							if (word_cnt == 4'd4)
								o_height <= din_s2[`VW_DIM_W-1:0];
						end
					end
					video_window_pkg::CMD_VSET: begin
						o_vset <= din_s2[`VW_DIM_W-1:0];
					end
					video_window_pkg::CMD_HSET: begin
						o_freescale <= din_s2[15];
						o_hset      <= din_s2[`VW_DIM_W-1:0];
					end
					video_window_pkg::CMD_ARC: begin
						case (word_cnt)
							4'd0: o_arc1x <= din_s2[`VW_AR_W-1:0];
							4'd1: o_arc1y <= din_s2[`VW_AR_W-1:0];
							4'd2: o_arc2x <= din_s2[`VW_AR_W-1:0];
							4'd3: o_arc2y <= din_s2[`VW_AR_W-1:0];
							default: ;
						endcase
					end
					video_window_pkg::CMD_LFB: begin
						// Words 1 to 4 carry base and size, unused here
						case (word_cnt)
							4'd0: o_lfb_en   <= din_s2[15];
							4'd5: o_lfb_hmin <= din_s2[`VW_DIM_W-1:0];
							4'd6: o_lfb_hmax <= din_s2[`VW_DIM_W-1:0];
							4'd7: o_lfb_vmin <= din_s2[`VW_DIM_W-1:0];
							4'd8: o_lfb_vmax <= din_s2[`VW_DIM_W-1:0];
							default: ;
						endcase
					end
					default: ;
				endcase
			end
		end
	end

	// Host keeps the request up until the ack rises
	a_ack_needs_req : assert property (@(posedge clk_sys) disable iff (resetd)
		$rose(o_io_ack) |-> req_s2);

endmodule

`default_nettype wire

//--- umuldiv.sv
////////////////////
// Computes mul1*mul2/div in 2 + 2*MUL_W cycles, result valid once busy drops
// Divide by zero returns all ones
////////////////////

`timescale 1ns/100ps
`default_nettype none

module umuldiv #(
	parameter int MUL_W = 12,
	parameter int DIV_W = 12
) (
	input  wire              clk_sys,
	input  wire              resetd,
	input  wire              i_start,
	input  wire [MUL_W-1:0]  i_mul1,
	input  wire [MUL_W-1:0]  i_mul2,
	input  wire [DIV_W-1:0]  i_div,
	output logic             o_busy,
	output logic [MUL_W-1:0] o_result
);

	localparam int PROD_W = 2 * MUL_W;
	localparam int CNT_W  = $clog2(PROD_W + 1);

	typedef enum logic [1:0] {ST_IDLE, ST_MUL, ST_DIV, ST_DONE} state_t;

	state_t state;
	logic [CNT_W-1:0] bit_cnt;
	logic [MUL_W-1:0] op_a;
	logic [MUL_W-1:0] op_b;
	logic [DIV_W-1:0] op_div;
	logic [PROD_W-1:0] prod;
	logic [PROD_W-1:0] quo;
	logic [DIV_W-1:0] rem;
	logic [DIV_W:0] trial;

	// Shift-and-add over the latched operands
	always_comb begin
		prod = '0;
		for (int i = 0; i < MUL_W; i++) begin
			if (op_b[i])
				prod = prod + (PROD_W'(op_a) << i);
		end
	end

	// Next dividend bit shifts in beside the partial remainder
	assign trial = {rem, quo[PROD_W-1]};

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			state   <= ST_IDLE;
			o_busy  <= 1'b0;
			bit_cnt <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (i_start) begin
						state  <= ST_MUL;
						o_busy <= 1'b1;
					end
				end
				ST_MUL: begin
					state   <= ST_DIV;
					bit_cnt <= CNT_W'(PROD_W);
				end
				ST_DIV: begin
					bit_cnt <= bit_cnt - 1'b1;
					if (bit_cnt == CNT_W'(1))
						state <= ST_DONE;
				end
				default: begin
					state  <= ST_IDLE;
					o_busy <= 1'b0;
				end
			endcase
		end
	end

	// Restoring division, quotient replaces the dividend bit by bit
	always_ff @(posedge clk_sys) begin
		case (state)
			ST_IDLE: begin
				if (i_start) begin
					op_a   <= i_mul1;
					op_b   <= i_mul2;
					op_div <= i_div;
				end
			end
			ST_MUL: begin
				quo <= prod;
				rem <= '0;
			end
			ST_DIV: begin
				if (trial >= {1'b0, op_div}) begin
					rem <= DIV_W'(trial - {1'b0, op_div});
					quo <= {quo[PROD_W-2:0], 1'b1};
				end else begin
					rem <= trial[DIV_W-1:0];
					quo <= {quo[PROD_W-2:0], 1'b0};
				end
			end
			default: o_result <= quo[MUL_W-1:0];
		endcase
	end

	// Caller must wait for busy to drop before the next operation
	a_no_start_busy : assert property (@(posedge clk_sys) disable iff (resetd)
		o_busy |-> !i_start);

endmodule

`default_nettype wire

//--- aspect_fit.sv
////////////////////
// Runs continuously, a config change shows up within two passes
// Quotients above 12 bits are truncated before the clamp
////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "video_window_defines.svh"

module aspect_fit (
	input  wire                            clk_sys,
	input  wire                            resetd,
	input  wire video_window_pkg::aspect_t i_arx,
	input  wire video_window_pkg::aspect_t i_ary,
	input  wire video_window_pkg::dim_t    i_width,
	input  wire video_window_pkg::dim_t    i_height,
	input  wire video_window_pkg::dim_t    i_hset,
	input  wire video_window_pkg::dim_t    i_vset,
	input  wire                            i_freescale,
	input  wire video_window_pkg::aspect_t i_arc1x,
	input  wire video_window_pkg::aspect_t i_arc1y,
	input  wire video_window_pkg::aspect_t i_arc2x,
	input  wire video_window_pkg::aspect_t i_arc2y,
	output video_window_pkg::dim_t         o_video_w,
	output video_window_pkg::dim_t         o_video_h,
	output logic                           o_fit_stb
);

	typedef enum logic [2:0] {
		ST_PICK, ST_W_GO, ST_W_WAIT, ST_H_GO, ST_H_WAIT, ST_CLAMP
	} state_t;

	state_t state;
	video_window_pkg::dim_t scr_w;
	video_window_pkg::dim_t scr_h;
	video_window_pkg::aspect_t ax;
	video_window_pkg::aspect_t ay;
	logic direct;
	video_window_pkg::dim_t wcalc;
	video_window_pkg::dim_t hcalc;

	logic md_start;
	logic md_busy;
	video_window_pkg::dim_t md_mul1;
	video_window_pkg::dim_t md_mul2;
	video_window_pkg::dim_t md_div;
	video_window_pkg::dim_t md_res;

	////////////////////
	// Screen size and aspect source
	////////////////////

	always_ff @(posedge clk_sys) begin
		scr_w <= (i_hset != '0 && i_hset < i_width) ? i_hset : i_width;
		scr_h <= (i_vset != '0 && i_vset < i_height) ? i_vset : i_height;

		// ARY of zero turns ARX into a custom slot index
		if (i_ary == '0) begin
			if (i_arx == video_window_pkg::aspect_t'(1)) begin
				ax <= i_arc1x;
				ay <= i_arc1y;
			end else if (i_arx == video_window_pkg::aspect_t'(2)) begin
				ax <= i_arc2x;
				ay <= i_arc2y;
			end else begin
				ax <= '0;
				ay <= '0;
			end
		end else begin
			ax <= i_arx;
			ay <= i_ary;
		end
	end

	assign direct = ax[`VW_AR_W-1] | ay[`VW_AR_W-1];

	umuldiv #(
		.MUL_W(`VW_DIM_W),
		.DIV_W(`VW_DIM_W)
	) u_muldiv (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.i_start  (md_start),
		.i_mul1   (md_mul1),
		.i_mul2   (md_mul2),
		.i_div    (md_div),
		.o_busy   (md_busy),
		.o_result (md_res)
	);

	////////////////////
	// Fit loop
	////////////////////

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			state     <= ST_PICK;
			md_start  <= 1'b0;
			o_fit_stb <= 1'b0;
		end else begin
			md_start  <= 1'b0;
			o_fit_stb <= 1'b0;
			case (state)
				ST_PICK: begin
					if (i_freescale || ax == '0 || ay == '0) begin
						wcalc <= scr_w;
						hcalc <= scr_h;
						state <= ST_CLAMP;
					end else if (direct) begin
						wcalc <= ax[`VW_DIM_W-1:0];
						hcalc <= ay[`VW_DIM_W-1:0];
						state <= ST_CLAMP;
					end else begin
						state <= ST_W_GO;
					end
				end
				// Width from the screen height
				ST_W_GO: begin
					md_mul1  <= scr_h;
					md_mul2  <= ax[`VW_DIM_W-1:0];
					md_div   <= ay[`VW_DIM_W-1:0];
					md_start <= 1'b1;
					state    <= ST_W_WAIT;
				end
				ST_W_WAIT: begin
					if (!md_start && !md_busy) begin
						wcalc <= md_res;
						state <= ST_H_GO;
					end
				end
				// Height from the screen width
				ST_H_GO: begin
					md_mul1  <= scr_w;
					md_mul2  <= ay[`VW_DIM_W-1:0];
					md_div   <= ax[`VW_DIM_W-1:0];
					md_start <= 1'b1;
					state    <= ST_H_WAIT;
				end
				ST_H_WAIT: begin
					if (!md_start && !md_busy) begin
						hcalc <= md_res;
						state <= ST_CLAMP;
					end
				end
				default: begin
					o_video_w <= (wcalc > scr_w) ? scr_w : wcalc;
					o_video_h <= (hcalc > scr_h) ? scr_h : hcalc;
					o_fit_stb <= 1'b1;
					state     <= ST_PICK;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- window_center.sv
////////////////////
// Fitted size must not exceed width and height, aspect_fit clamps it
////////////////////

`timescale 1ns/100ps
`default_nettype none

module window_center (
	input  wire                         clk_sys,
	input  wire                         resetd,
	input  wire video_window_pkg::dim_t i_width,
	input  wire video_window_pkg::dim_t i_height,
	input  wire video_window_pkg::dim_t i_video_w,
	input  wire video_window_pkg::dim_t i_video_h,
	input  wire                         i_fit_stb,
	input  wire                         i_lfb_en,
	input  wire video_window_pkg::dim_t i_lfb_hmin,
	input  wire video_window_pkg::dim_t i_lfb_hmax,
	input  wire video_window_pkg::dim_t i_lfb_vmin,
	input  wire video_window_pkg::dim_t i_lfb_vmax,
	output video_window_pkg::dim_t      o_hmin,
	output video_window_pkg::dim_t      o_hmax,
	output video_window_pkg::dim_t      o_vmin,
	output video_window_pkg::dim_t      o_vmax
);

	video_window_pkg::dim_t h_off;
	video_window_pkg::dim_t v_off;

	// Half the spare border, rounded down
	assign h_off = (i_width - i_video_w) >> 1;
	assign v_off = (i_height - i_video_h) >> 1;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			o_hmin <= '0;
			o_hmax <= '0;
			o_vmin <= '0;
			o_vmax <= '0;
		end else if (i_fit_stb) begin
			if (i_lfb_en) begin
				o_hmin <= i_lfb_hmin;
				o_hmax <= i_lfb_hmax;
				o_vmin <= i_lfb_vmin;
				o_vmax <= i_lfb_vmax;
			end else begin
				o_hmin <= h_off;
				o_hmax <= h_off + i_video_w - 12'd1;
				o_vmin <= v_off;
				o_vmax <= v_off + i_video_h - 12'd1;
			end
		end
	end

	// Relies on the clamp upstream keeping the fitted width inside the line
	a_h_order : assert property (@(posedge clk_sys) disable iff (resetd)
		$past(i_fit_stb && !i_lfb_en && i_video_w != '0) |-> o_hmax >= o_hmin);

endmodule

`default_nettype wire

//--- video_window_top.sv
////////////////////
// Core aspect inputs are treated as static, no synchroniser on them
////////////////////

`timescale 1ns/100ps
`default_nettype none

module video_window_top (
	input  wire                            clk_sys,
	input  wire                            resetd,
	input  wire                            i_io_sel,
	input  wire                            i_io_clk,
	input  wire video_window_pkg::io_word_t i_io_din,
	output logic                           o_io_ack,
	input  wire video_window_pkg::aspect_t i_arx,
	input  wire video_window_pkg::aspect_t i_ary,
	output video_window_pkg::dim_t         o_hmin,
	output video_window_pkg::dim_t         o_hmax,
	output video_window_pkg::dim_t         o_vmin,
	output video_window_pkg::dim_t         o_vmax
);

	// Configuration from the host
	video_window_pkg::dim_t    width;
	video_window_pkg::dim_t    height;
	video_window_pkg::dim_t    hset;
	video_window_pkg::dim_t    vset;
	logic                      freescale;
	video_window_pkg::aspect_t arc1x;
	video_window_pkg::aspect_t arc1y;
	video_window_pkg::aspect_t arc2x;
	video_window_pkg::aspect_t arc2y;
	logic                      lfb_en;
	video_window_pkg::dim_t    lfb_hmin;
	video_window_pkg::dim_t    lfb_hmax;
	video_window_pkg::dim_t    lfb_vmin;
	video_window_pkg::dim_t    lfb_vmax;

	// Fit result
	video_window_pkg::dim_t    video_w;
	video_window_pkg::dim_t    video_h;
	logic                      fit_stb;

	hps_cmd_decode u_decode (
		.clk_sys     (clk_sys),
		.resetd      (resetd),
		.i_io_sel    (i_io_sel),
		.i_io_clk    (i_io_clk),
		.i_io_din    (i_io_din),
		.o_io_ack    (o_io_ack),
		.o_width     (width),
		.o_height    (height),
		.o_hset      (hset),
		.o_vset      (vset),
		.o_freescale (freescale),
		.o_arc1x     (arc1x),
		.o_arc1y     (arc1y),
		.o_arc2x     (arc2x),
		.o_arc2y     (arc2y),
		.o_lfb_en    (lfb_en),
		.o_lfb_hmin  (lfb_hmin),
		.o_lfb_hmax  (lfb_hmax),
		.o_lfb_vmin  (lfb_vmin),
		.o_lfb_vmax  (lfb_vmax)
	);

	aspect_fit u_fit (
		.clk_sys     (clk_sys),
		.resetd      (resetd),
		.i_arx       (i_arx),
		.i_ary       (i_ary),
		.i_width     (width),
		.i_height    (height),
		.i_hset      (hset),
		.i_vset      (vset),
		.i_freescale (freescale),
		.i_arc1x     (arc1x),
		.i_arc1y     (arc1y),
		.i_arc2x     (arc2x),
		.i_arc2y     (arc2y),
		.o_video_w   (video_w),
		.o_video_h   (video_h),
		.o_fit_stb   (fit_stb)
	);

	window_center u_center (
		.clk_sys    (clk_sys),
		.resetd     (resetd),
		.i_width    (width),
		.i_height   (height),
		.i_video_w  (video_w),
		.i_video_h  (video_h),
		.i_fit_stb  (fit_stb),
		.i_lfb_en   (lfb_en),
		.i_lfb_hmin (lfb_hmin),
		.i_lfb_hmax (lfb_hmax),
		.i_lfb_vmin (lfb_vmin),
		.i_lfb_vmax (lfb_vmax),
		.o_hmin     (o_hmin),
		.o_hmax     (o_hmax),
		.o_vmin     (o_vmin),
		.o_vmax     (o_vmax)
	);

endmodule

`default_nettype wire

//--- tb_video_window.sv
////////////////////
// Expected windows are worked out by hand from the window rule
// Rows run in order and each builds on the configuration left by the last
////////////////////

`timescale 1ns/100ps
`default_nettype none

module tb_video_window;

	localparam int MAX_ROWS    = 16;
	localparam int MAX_WORDS   = 10;
	localparam int HS_TIMEOUT  = 50;
	localparam int WIN_TIMEOUT = 200;

	logic                       clk_sys;
	logic                       resetd;
	logic                       i_io_sel;
	logic                       i_io_clk;
	video_window_pkg::io_word_t i_io_din;
	logic                       o_io_ack;
	video_window_pkg::aspect_t  i_arx;
	video_window_pkg::aspect_t  i_ary;
	video_window_pkg::dim_t     o_hmin;
	video_window_pkg::dim_t     o_hmax;
	video_window_pkg::dim_t     o_vmin;
	video_window_pkg::dim_t     o_vmax;

	// Stimulus and expected window per row
	int                         n_rows;
	string                      row_name [MAX_ROWS];
	int                         row_len [MAX_ROWS];
	video_window_pkg::io_word_t row_words [MAX_ROWS][MAX_WORDS];
	int                         row_arx [MAX_ROWS];
	int                         row_ary [MAX_ROWS];
	int                         exp_hmin [MAX_ROWS];
	int                         exp_hmax [MAX_ROWS];
	int                         exp_vmin [MAX_ROWS];
	int                         exp_vmax [MAX_ROWS];

	video_window_top DUT (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.i_io_sel (i_io_sel),
		.i_io_clk (i_io_clk),
		.i_io_din (i_io_din),
		.o_io_ack (o_io_ack),
		.i_arx    (i_arx),
		.i_ary    (i_ary),
		.o_hmin   (o_hmin),
		.o_hmax   (o_hmax),
		.o_vmin   (o_vmin),
		.o_vmax   (o_vmax)
	);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	////////////////////
	// Checking helpers
	////////////////////

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("STATUS: FAIL");
		$fatal(1, "Simulation stopped on first error");
	endtask

	task automatic check_value(input string test, input string what,
		input int expected, input int actual);
		assert (expected == actual)
		else stop_on_error($sformatf("ERROR: %s %s expected %0d actual %0d",
			test, what, expected, actual));
	endtask

	// One clock, then 1 ns so outputs have settled
	task automatic next_cycle();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n)
			next_cycle();
	endtask

	////////////////////
	// Host link
	////////////////////

	task automatic wait_ack(input logic level, input string step);
		int cnt;
		cnt = 0;
		while (o_io_ack !== level) begin
			next_cycle();
			cnt++;
			if (cnt > HS_TIMEOUT)
				stop_on_error($sformatf("Timeout: acknowledge did not %s within %0d cycles",
					step, HS_TIMEOUT));
		end
	endtask

	// Data a cycle ahead of the request
	task automatic write_word(input video_window_pkg::io_word_t word);
		i_io_din = word;
		next_cycle();
		i_io_clk = 1'b1;
		wait_ack(1'b1, "rise");
		i_io_clk = 1'b0;
		wait_ack(1'b0, "fall");
	endtask

	// Select frames the whole command, dropping it ends or aborts the command
	task automatic send_command(input int row);
		if (row_len[row] > 0) begin
			i_io_sel = 1'b1;
			for (int w = 0; w < row_len[row]; w++)
				write_word(row_words[row][w]);
			i_io_sel = 1'b0;
			idle_cycles(4);
		end
	endtask

	////////////////////
	// Window checks
	////////////////////

	function automatic bit window_matches(input int row);
		return int'(o_hmin) == exp_hmin[row] && int'(o_hmax) == exp_hmax[row] &&
			int'(o_vmin) == exp_vmin[row] && int'(o_vmax) == exp_vmax[row];
	endfunction

	task automatic check_window(input int row);
		int cnt;
		cnt = 0;
		while (!window_matches(row) && cnt < WIN_TIMEOUT) begin
			next_cycle();
			cnt++;
		end
		if (!window_matches(row))
			$display("Window for %s did not settle within %0d cycles",
				row_name[row], WIN_TIMEOUT);
		check_value(row_name[row], "hmin", exp_hmin[row], int'(o_hmin));
		check_value(row_name[row], "hmax", exp_hmax[row], int'(o_hmax));
		check_value(row_name[row], "vmin", exp_vmin[row], int'(o_vmin));
		check_value(row_name[row], "vmax", exp_vmax[row], int'(o_vmax));
	endtask

	////////////////////
	// Table
	////////////////////

	task automatic add_row(input string name, input int arx, input int ary,
		input int hmin, input int hmax, input int vmin, input int vmax);
		row_name[n_rows] = name;
		row_len[n_rows]  = 0;
		row_arx[n_rows]  = arx;
		row_ary[n_rows]  = ary;
		exp_hmin[n_rows] = hmin;
		exp_hmax[n_rows] = hmax;
		exp_vmin[n_rows] = vmin;
		exp_vmax[n_rows] = vmax;
		n_rows++;
	endtask

	// Appends a host word to the most recent row
	task automatic add_word(input int word);
		row_words[n_rows-1][row_len[n_rows-1]] = 16'(word);
		row_len[n_rows-1]++;
	endtask

	task automatic build_table();
		add_row("reset_defaults", 0, 0, 0, 1919, 0, 1079);
		add_row("aspect_4_3", 4, 3, 240, 1679, 0, 1079);
		// 1920*10/16 = 1200 clamps to 1080
		add_row("aspect_16_10", 16, 10, 96, 1823, 0, 1079);

		add_row("timing_1280x720", 0, 0, 0, 1279, 0, 719);
		add_word(int'(video_window_pkg::CMD_TIMING));
		add_word(1280);
		add_word(0);
		add_word(0);
		add_word(0);
		add_word(720);
		add_word(0);
		add_word(0);
		add_word(0);

		add_row("vset_600", 0, 0, 0, 1279, 60, 659);
		add_word(int'(video_window_pkg::CMD_VSET));
		add_word(600);
		// Free scale wins over the 4:3 aspect
		add_row("hset_freescale", 4, 3, 140, 1139, 60, 659);
		add_word(int'(video_window_pkg::CMD_HSET));
		add_word('h8000 | 1000);
		add_row("clear_hset", 0, 0, 0, 1279, 60, 659);
		add_word(int'(video_window_pkg::CMD_HSET));
		add_word(0);
		add_row("clear_vset", 0, 0, 0, 1279, 0, 719);
		add_word(int'(video_window_pkg::CMD_VSET));
		add_word(0);

		// arc1 is 4:3, arc2 a direct 800x500
		add_row("arc1_slot", 1, 0, 160, 1119, 0, 719);
		add_word(int'(video_window_pkg::CMD_ARC));
		add_word(4);
		add_word(3);
		add_word('h1000 | 800);
		add_word('h1000 | 500);
		add_row("arc2_direct", 2, 0, 240, 1039, 110, 609);

		add_row("lfb_on", 2, 0, 10, 20, 30, 40);
		add_word(int'(video_window_pkg::CMD_LFB));
		add_word('h8000);
		for (int i = 0; i < 4; i++)
			add_word(0);
		add_word(10);
		add_word(20);
		add_word(30);
		add_word(40);
		add_row("lfb_off", 2, 0, 240, 1039, 110, 609);
		add_word(int'(video_window_pkg::CMD_LFB));
		add_word(0);

		// Cut off before the height word, so the window stays put
		add_row("timing_abort", 2, 0, 240, 1039, 110, 609);
		add_word(int'(video_window_pkg::CMD_TIMING));
		add_word(1280);
		add_word(0);
		add_row("vset_after_abort", 0, 0, 0, 1279, 60, 659);
		add_word(int'(video_window_pkg::CMD_VSET));
		add_word(600);
	endtask

	////////////////////
	// Main sequence
	////////////////////

	initial begin
		resetd   = 1'b1;
		i_io_sel = 1'b0;
		i_io_clk = 1'b0;
		i_io_din = '0;
		i_arx    = '0;
		i_ary    = '0;
		n_rows   = 0;
		build_table();

		repeat (2)
			@(posedge clk_sys);
		#1;
		resetd = 1'b0;
		check_value("reset", "io_ack", 0, int'(o_io_ack));
		check_value("reset", "hmax", 0, int'(o_hmax));

		for (int r = 0; r < n_rows; r++) begin
			i_arx = video_window_pkg::aspect_t'(row_arx[r]);
			i_ary = video_window_pkg::aspect_t'(row_ary[r]);
			send_command(r);
			check_window(r);
		end

		$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb.f
+incdir+.
video_window_pkg.sv
hps_cmd_decode.sv
umuldiv.sv
aspect_fit.sv
window_center.sv
video_window_top.sv
tb_video_window.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_video_window -o vsim
	./obj_dir/vsim | tee sim.log
	grep -q "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
